/* rtl/conv_defines.svh */
// image geometry, datapath widths and default kernels for the stereo front end
// include wherever a macro is needed; the guard keeps repeated includes harmless
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// frame geometry in pixels
`define IMG_WIDTH     8
`define IMG_HEIGHT    6

`define PIX_WIDTH     8
`define ACC_WIDTH     20

// scale and saturation applied after the sum
`define CONV_SHIFT    4
`define RELU_MAX      127

// input FIFO entries, also the credits the upstream starts with
`define IN_FIFO_DEPTH 4
`define OUT_CREDITS   4

// nine signed taps, top-left in the most significant field
`define KERNEL_LEFT  { \
    8'h01, 8'h02, 8'h01, \
    8'h02, 8'h08, 8'h02, \
    8'h01, 8'h02, 8'h01}

// sharpening kernel, centre weighted against its neighbours
`define KERNEL_RIGHT { \
    8'hFF, 8'hFF, 8'hFF, \
    8'hFF, 8'h0C, 8'hFF, \
    8'hFF, 8'hFF, 8'hFF}

`endif

/* rtl/conv_pkg.sv */
// shared types for the stereo convolution front end
// in_word_u is the word carried through the input FIFO
`include "conv_defines.svh"

package conv_pkg;

    typedef logic signed [`PIX_WIDTH-1:0] pixel_t;

    // holds the nine-tap sum before scaling
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    typedef struct packed {
        pixel_t left;
        pixel_t right;
    } stereo_pair_t;

    // raw view for storage, beat view for decoding
    typedef union packed {
        logic [2*`PIX_WIDTH:0] raw;
        struct packed {
            logic         sof;
            stereo_pair_t pair;
        } beat;
    } in_word_u;

endpackage

/* rtl/pixel_fifo.sv */
`timescale 1ns/100ps
// input buffer for stereo pixel words, popped once per pipeline step
// every pop hands one credit back to the upstream a cycle later
`include "conv_defines.svh"

module pixel_fifo
    import conv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     wr_valid_i,
    input  in_word_u wr_word_i,
    input  logic     pop_i,
    output logic     empty_o,
    output in_word_u rd_word_o,
    output logic     credit_o
);

    localparam int PTR_W = $clog2(`IN_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`IN_FIFO_DEPTH - 1);
    localparam logic [PTR_W:0]   DEPTH_CNT = (PTR_W + 1)'(`IN_FIFO_DEPTH);

    logic [$bits(in_word_u)-1:0] mem [`IN_FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic                        full;

    assign empty_o = (count == '0);
    assign full    = (count == DEPTH_CNT);

    always_comb begin
        rd_word_o.raw = mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_ptr] <= wr_word_i.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_valid_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit per entry freed
            credit_o <= pop_i;
        end
    end

    // upstream must hold a credit for every beat it sends
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(wr_valid_i && full))
        else $error("pixel_fifo: write while full");

    // step logic only advances on buffered data
    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pop_i && empty_o))
        else $error("pixel_fifo: pop while empty");

endmodule

/* rtl/window_conv.sv */
`timescale 1ns/100ps
// one branch of the front end: line buffers, 3x3 window, MAC, shift and ReLU
// a result and its markers appear one cycle after the step that completes a window
`include "conv_defines.svh"

module window_conv
    import conv_pkg::*;
#(
    parameter logic [9*`PIX_WIDTH-1:0] KERNEL = `KERNEL_LEFT
)
(
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   step_i,
    input  logic   sof_i,
    input  pixel_t pix_i,
    output logic   valid_o,
    output pixel_t result_o,
    output logic   sop_o,
    output logic   eop_o,
    output logic   sof_o,
    output logic   eof_o
);

    localparam int COL_W = $clog2(`IMG_WIDTH);
    localparam int ROW_W = $clog2(`IMG_HEIGHT);
    localparam logic [COL_W-1:0] LAST_COL  = COL_W'(`IMG_WIDTH - 1);
    localparam logic [ROW_W-1:0] LAST_ROW  = ROW_W'(`IMG_HEIGHT - 1);
    localparam logic [COL_W-1:0] FIRST_COL = COL_W'(2);
    localparam logic [ROW_W-1:0] FIRST_ROW = ROW_W'(2);

    logic [COL_W-1:0] col;
    logic [COL_W-1:0] cur_col;
    logic [ROW_W-1:0] row;
    logic [ROW_W-1:0] cur_row;
    logic             win_step;

    // previous two lines, indexed by column
    pixel_t line0 [`IMG_WIDTH];
    pixel_t line1 [`IMG_WIDTH];
    // row 0 is the oldest line, column 0 the oldest pixel
    pixel_t win [3][3];

    acc_t conv_sum;
    acc_t scaled;

    function automatic pixel_t coef(input int idx);
        return pixel_t'(KERNEL[(8 - idx) * `PIX_WIDTH +: `PIX_WIDTH]);
    endfunction

    // frame start puts the current pixel at the origin
    assign cur_col  = sof_i ? '0 : col;
    assign cur_row  = sof_i ? '0 : row;
    assign win_step = step_i && (cur_col >= FIRST_COL) && (cur_row >= FIRST_ROW);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            col <= '0;
            row <= '0;
        end else if (step_i) begin
            if (cur_col == LAST_COL) begin
                col <= '0;
                row <= (cur_row == LAST_ROW) ? '0 : cur_row + 1'b1;
            end else begin
                col <= cur_col + 1'b1;
                row <= cur_row;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_i) begin
            line1[cur_col] <= line0[cur_col];
            line0[cur_col] <= pix_i;
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            win[0][2] <= line1[cur_col];
            win[1][2] <= line0[cur_col];
            win[2][2] <= pix_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
        end else begin
            valid_o <= win_step;
            sop_o   <= win_step && (cur_col == FIRST_COL);
            eop_o   <= win_step && (cur_col == LAST_COL);
            sof_o   <= win_step && (cur_col == FIRST_COL) && (cur_row == FIRST_ROW);
            eof_o   <= win_step && (cur_col == LAST_COL) && (cur_row == LAST_ROW);
        end
    end

    // nine products of the frozen window
    always_comb begin
        conv_sum = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                conv_sum = conv_sum + acc_t'(win[r][c]) * acc_t'(coef(r * 3 + c));
            end
        end
    end

    assign scaled = conv_sum >>> `CONV_SHIFT;

    // saturating ReLU
    always_comb begin
        if (scaled < 0) begin
            result_o = '0;
        end else if (scaled > acc_t'(`RELU_MAX)) begin
            result_o = pixel_t'(`RELU_MAX);
        end else begin
            result_o = pixel_t'(scaled);
        end
    end

    // upstream framing has to agree with the position counters
    sof_at_origin: assert property (@(posedge clk) disable iff (!rst_n_i)
        (step_i && sof_i) |-> (col == '0 && row == '0))
        else $error("window_conv: sof_i away from frame start");

endmodule

/* rtl/channel_concat.sv */
`timescale 1ns/100ps
// joins the left and right branch results into one output pair
// also owns the output credits and decides when the pipeline steps
`include "conv_defines.svh"

module channel_concat
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         fifo_empty_i,
    input  logic         out_credit_i,
    output logic         step_o,
    input  logic         l_valid_i,
    input  pixel_t       l_result_i,
    input  pixel_t       r_result_i,
    input  logic         r_valid_i,
    input  logic         r_sop_i,
    input  logic         r_eop_i,
    input  logic         r_sof_i,
    input  logic         r_eof_i,
    output logic         out_valid_o,
    output stereo_pair_t out_data_o,
    output logic         out_sop_o,
    output logic         out_eop_o,
    output logic         out_sof_o,
    output logic         out_eof_o
);

    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);
    localparam logic [CRD_W-1:0] CRD_INIT = CRD_W'(`OUT_CREDITS);

    logic [CRD_W-1:0] credit_cnt;
    logic             spend;

    assign spend = l_valid_i && r_valid_i;

    // a result in flight already owns a credit
    assign step_o = !fifo_empty_i && (credit_cnt > CRD_W'(spend));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt <= CRD_INIT;
        end else begin
            case ({out_credit_i, spend})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (spend) begin
            out_data_o.left  <= l_result_i;
            out_data_o.right <= r_result_i;
        end
    end

    // markers follow the right branch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            out_sop_o   <= 1'b0;
            out_eop_o   <= 1'b0;
            out_sof_o   <= 1'b0;
            out_eof_o   <= 1'b0;
        end else begin
            out_valid_o <= spend;
            out_sop_o   <= r_sop_i;
            out_eop_o   <= r_eop_i;
            out_sof_o   <= r_sof_i;
            out_eof_o   <= r_eof_i;
        end
    end

    // both branches step together
    lr_valid_match: assert property (@(posedge clk) disable iff (!rst_n_i)
        l_valid_i == r_valid_i)
        else $error("channel_concat: branch valids differ");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_cnt <= CRD_INIT)
        else $error("channel_concat: more credits returned than granted");

endmodule

/* rtl/conv_top.sv */
`timescale 1ns/100ps
// stereo convolution front end, one pixel pair in per beat under credit flow
// input FIFO feeds a left and a right 3x3 branch whose results are paired
`include "conv_defines.svh"

module conv_top
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         in_valid_i,
    input  logic         in_sof_i,
    input  pixel_t       in_left_i,
    input  pixel_t       in_right_i,
    output logic         in_credit_o,
    input  logic         out_credit_i,
    output logic         out_valid_o,
    output stereo_pair_t out_data_o,
    output logic         out_sop_o,
    output logic         out_eop_o,
    output logic         out_sof_o,
    output logic         out_eof_o
);

    in_word_u in_word;
    in_word_u fifo_word;
    logic     fifo_empty;
    logic     step;

    logic     l_valid;
    pixel_t   l_result;
    logic     r_valid;
    pixel_t   r_result;
    logic     r_sop;
    logic     r_eop;
    logic     r_sof;
    logic     r_eof;

    always_comb begin
        in_word.beat.sof        = in_sof_i;
        in_word.beat.pair.left  = in_left_i;
        in_word.beat.pair.right = in_right_i;
    end

    pixel_fifo u_fifo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (in_valid_i),
        .wr_word_i  (in_word),
        .pop_i      (step),
        .empty_o    (fifo_empty),
        .rd_word_o  (fifo_word),
        .credit_o   (in_credit_o)
    );

    // framing comes from the right branch, so the left markers stay open
    window_conv #(.KERNEL(`KERNEL_LEFT)) u_left (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .step_i   (step),
        .sof_i    (fifo_word.beat.sof),
        .pix_i    (fifo_word.beat.pair.left),
        .valid_o  (l_valid),
        .result_o (l_result),
        .sop_o    (),
        .eop_o    (),
        .sof_o    (),
        .eof_o    ()
    );

    window_conv #(.KERNEL(`KERNEL_RIGHT)) u_right (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .step_i   (step),
        .sof_i    (fifo_word.beat.sof),
        .pix_i    (fifo_word.beat.pair.right),
        .valid_o  (r_valid),
        .result_o (r_result),
        .sop_o    (r_sop),
        .eop_o    (r_eop),
        .sof_o    (r_sof),
        .eof_o    (r_eof)
    );

    channel_concat u_concat (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fifo_empty_i (fifo_empty),
        .out_credit_i (out_credit_i),
        .step_o       (step),
        .l_valid_i    (l_valid),
        .l_result_i   (l_result),
        .r_result_i   (r_result),
        .r_valid_i    (r_valid),
        .r_sop_i      (r_sop),
        .r_eop_i      (r_eop),
        .r_sof_i      (r_sof),
        .r_eof_i      (r_eof),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_sop_o    (out_sop_o),
        .out_eop_o    (out_eop_o),
        .out_sof_o    (out_sof_o),
        .out_eof_o    (out_eof_o)
    );

endmodule

/* dv/conv_tb.sv */
`timescale 1ns/100ps
// testbench for conv_top: random stereo frames under credit flow on both sides
// a software model of the convolution feeds the checking assertions
`include "conv_defines.svh"

module conv_tb
    import conv_pkg::*;
();

    localparam int W       = `IMG_WIDTH;
    localparam int H       = `IMG_HEIGHT;
    localparam int FRAMES  = 3;
    localparam int WINDOWS = (W - 2) * (H - 2);
    localparam int TIMEOUT = 2000;
    localparam logic [9*`PIX_WIDTH-1:0] K_LEFT  = `KERNEL_LEFT;
    localparam logic [9*`PIX_WIDTH-1:0] K_RIGHT = `KERNEL_RIGHT;

    typedef struct packed {
        stereo_pair_t data;
        logic         sop;
        logic         eop;
        logic         sof;
        logic         eof;
    } exp_beat_t;

    logic         clk;
    logic         rst_n_i;
    logic         rst_q = 1'b0;
    logic         in_valid_i;
    logic         in_sof_i;
    pixel_t       in_left_i;
    pixel_t       in_right_i;
    logic         in_credit_o;
    logic         out_credit_i = 1'b0;
    logic         out_valid_o;
    stereo_pair_t out_data_o;
    logic         out_sop_o;
    logic         out_eop_o;
    logic         out_sof_o;
    logic         out_eof_o;

    pixel_t    left_img  [FRAMES][H][W];
    pixel_t    right_img [FRAMES][H][W];
    exp_beat_t exp_q [$];
    exp_beat_t exp_cur;
    logic      exp_present = 1'b0;
    int        beats_sent = 0;
    int        credit_pulses = 0;
    int        out_seen = 0;
    int        crd_given = 0;
    logic      credit_enable;
    logic      stall_end;
    logic      drained;

    conv_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_sof_i     (in_sof_i),
        .in_left_i    (in_left_i),
        .in_right_i   (in_right_i),
        .in_credit_o  (in_credit_o),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_sop_o    (out_sop_o),
        .out_eop_o    (out_eop_o),
        .out_sof_o    (out_sof_o),
        .out_eof_o    (out_eof_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // signed tap, top-left is the most significant field
    function automatic int tap(input logic [9*`PIX_WIDTH-1:0] k, input int idx);
        logic signed [`PIX_WIDTH-1:0] field;
        field = k[(8 - idx) * `PIX_WIDTH +: `PIX_WIDTH];
        return int'(field);
    endfunction

    // window with its bottom-right pixel at (r, c)
    function automatic pixel_t expected_pixel(input bit right_side, input int f,
                                              input int r, input int c);
        int sum;
        int p;
        sum = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                p = right_side ? int'(right_img[f][r-2+i][c-2+j])
                               : int'(left_img[f][r-2+i][c-2+j]);
                sum = sum + p * tap(right_side ? K_RIGHT : K_LEFT, i * 3 + j);
            end
        end
        sum = sum >>> `CONV_SHIFT;
        if (sum < 0) begin
            sum = 0;
        end else if (sum > `RELU_MAX) begin
            sum = `RELU_MAX;
        end
        return pixel_t'(sum);
    endfunction

    // frame 1 is all positive so the left branch saturates
    task automatic build_frames();
        exp_beat_t beat;
        for (int f = 0; f < FRAMES; f++) begin
            for (int r = 0; r < H; r++) begin
                for (int c = 0; c < W; c++) begin
                    if (f == 1) begin
                        left_img[f][r][c]  = pixel_t'($urandom_range(127, 0));
                        right_img[f][r][c] = pixel_t'($urandom_range(127, 0));
                    end else begin
                        left_img[f][r][c]  = pixel_t'($urandom);
                        right_img[f][r][c] = pixel_t'($urandom);
                    end
                end
            end
            for (int r = 2; r < H; r++) begin
                for (int c = 2; c < W; c++) begin
                    beat.data.left  = expected_pixel(1'b0, f, r, c);
                    beat.data.right = expected_pixel(1'b1, f, r, c);
                    beat.sop = (c == 2);
                    beat.eop = (c == W - 1);
                    beat.sof = (r == 2) && (c == 2);
                    beat.eof = (r == H - 1) && (c == W - 1);
                    exp_q.push_back(beat);
                end
            end
        end
    endtask

    task automatic send_frame(input int f);
        int cycles;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                cycles = 0;
                @(posedge clk);
                #1;
                in_valid_i = 1'b0;
                while (beats_sent >= `IN_FIFO_DEPTH + credit_pulses
                       || $urandom_range(5, 0) == 0) begin
                    if (cycles >= TIMEOUT) begin
                        fail_run("timeout waiting for an input credit");
                    end else begin
                        cycles++;
                        @(posedge clk);
                        #1;
                    end
                end
                in_valid_i = 1'b1;
                in_sof_i   = (r == 0) && (c == 0);
                in_left_i  = left_img[f][r][c];
                in_right_i = right_img[f][r][c];
                beats_sent++;
            end
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        in_sof_i   = 1'b0;
    endtask

    task automatic wait_outputs(input int n);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (out_seen < n) begin
            if (cycles >= TIMEOUT) begin
                fail_run("timeout waiting for output beats");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // no credits until the initial grant is used up, then a long stall mid-run
    task automatic pace_credits();
        wait_outputs(`OUT_CREDITS);
        repeat (40) @(negedge clk);
        #1 stall_end = 1'b1;
        @(negedge clk);
        #1 stall_end = 1'b0;
        credit_enable = 1'b1;
        wait_outputs(2 * WINDOWS - 6);
        #1 credit_enable = 1'b0;
        repeat (60) @(negedge clk);
        #1 credit_enable = 1'b1;
    endtask

    always @(posedge clk) begin
        rst_q <= rst_n_i;
    end

    // in_credit_o is stable half a cycle after the edge that sets it
    always @(negedge clk) begin
        #1;
        if (rst_n_i && in_credit_o) begin
            credit_pulses++;
        end
    end

    // receiver takes each beat and hands credits back at random gaps
    always @(posedge clk) begin
        #1;
        if (rst_n_i && out_valid_o) begin
            out_seen++;
            exp_present = (exp_q.size() != 0);
            if (exp_present) begin
                exp_cur = exp_q.pop_front();
            end
        end
        out_credit_i = 1'b0;
        if (rst_n_i && credit_enable && crd_given < out_seen
            && $urandom_range(2, 0) != 0) begin
            out_credit_i = 1'b1;
            crd_given++;
        end
    end

    reset_quiet: assert property (@(negedge clk)
        (!rst_n_i || !rst_q) |-> (!out_valid_o && !in_credit_o && !out_sop_o
                                  && !out_eop_o && !out_sof_o && !out_eof_o))
        else fail_run("output active during or just after reset");

    beat_expected: assert property (@(negedge clk) disable iff (!rst_n_i)
        out_valid_o |-> exp_present)
        else fail_run("output beat arrived with no window left in the model");

    data_match: assert property (@(negedge clk) disable iff (!rst_n_i)
        out_valid_o |-> (out_data_o == exp_cur.data))
        else fail_run($sformatf("mismatch out_data_o expected %h got %h",
                                exp_cur.data, out_data_o));

    marker_match: assert property (@(negedge clk) disable iff (!rst_n_i)
        out_valid_o |-> ({out_sop_o, out_eop_o, out_sof_o, out_eof_o}
                         == {exp_cur.sop, exp_cur.eop, exp_cur.sof, exp_cur.eof}))
        else fail_run($sformatf(
            "mismatch out_sop_o/out_eop_o/out_sof_o/out_eof_o expected %h got %h",
            {exp_cur.sop, exp_cur.eop, exp_cur.sof, exp_cur.eof},
            {out_sop_o, out_eop_o, out_sof_o, out_eof_o}));

    out_credit_bound: assert property (@(negedge clk) disable iff (!rst_n_i)
        out_seen <= `OUT_CREDITS + crd_given)
        else fail_run("more output beats than credits granted");

    // the DUT hands back at most one credit per beat it was sent
    in_credit_bound: assert property (@(negedge clk) disable iff (!rst_n_i)
        credit_pulses <= beats_sent)
        else fail_run("input credit returned for a beat that was never sent");

    initial_grant: assert property (@(negedge clk) disable iff (!rst_n_i)
        stall_end |-> (out_seen == `OUT_CREDITS))
        else fail_run($sformatf(
            "mismatch out_valid_o beats before first credit expected %h got %h",
            `OUT_CREDITS, out_seen));

    credits_drained: assert property (@(negedge clk) disable iff (!rst_n_i)
        drained |-> (credit_pulses == beats_sent))
        else fail_run($sformatf("mismatch in_credit_o pulses expected %h got %h",
                                beats_sent, credit_pulses));

    initial begin
        void'($urandom(32'h6355_3fea));
        rst_n_i       = 1'b0;
        in_valid_i    = 1'b0;
        in_sof_i      = 1'b0;
        in_left_i     = '0;
        in_right_i    = '0;
        credit_enable = 1'b0;
        stall_end     = 1'b0;
        drained       = 1'b0;
        build_frames();
        repeat (8) @(posedge clk);
        #1 rst_n_i = 1'b1;
        fork
            begin
                for (int f = 0; f < FRAMES; f++) begin
                    send_frame(f);
                end
            end
            pace_credits();
        join
        wait_outputs(FRAMES * WINDOWS);
        // last credit pulse trails the final pop
        repeat (4) @(negedge clk);
        #1 drained = 1'b1;
        repeat (2) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/conv_pkg.sv
rtl/pixel_fifo.sv
rtl/window_conv.sv
rtl/channel_concat.sv
rtl/conv_top.sv
dv/conv_tb.sv

/* run.sh */
#!/bin/sh
# builds the stereo convolution testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module conv_tb \
    -Mdir obj_dir -o conv_sim

sim_out=$(./obj_dir/conv_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
